/* ras_pkg.sv */
`default_nettype none

package ras_pkg;

    // -------------------- widths

    localparam int NUM_HARTS_MAX = 8;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(NUM_HARTS_MAX)-1:0] hart_t;

    // -------------------- RV32I opcodes

    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // -------------------- bundles

    // One instruction as it leaves fetch
    typedef struct packed {
        logic   valid;
        hart_t  hart;
        addr_t  pc;
        instr_t instr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        hart_t hart;
        addr_t target;  // Undefined when the stack was empty
        logic  fail;
    } ras_pred_t;

endpackage

`default_nettype wire

/* call_ret_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module call_ret_decode #(
    parameter int NUM_HARTS = 4
) (
    input  logic                clk,
    input  logic                resetn,
    input  ras_pkg::fetch_req_t fetch,
    output logic [NUM_HARTS-1:0] push,
    output logic [NUM_HARTS-1:0] pop,
    output ras_pkg::addr_t      ret_pc,
    output logic                pop_valid,
    output ras_pkg::hart_t      pop_hart
);

    logic [6:0]           opcode;
    logic [4:0]           rd;
    logic [4:0]           rs1;
    logic                 rd_link;
    logic                 rs1_link;
    logic                 hart_ok;
    logic                 is_call;
    logic                 is_ret;
    logic [NUM_HARTS-1:0] hart_sel;

    assign opcode = fetch.instr[6:0];
    assign rd     = fetch.instr[11:7];
    assign rs1    = fetch.instr[19:15];

    // x1 and x5 are the link registers of the calling convention
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // A hart number beyond the built stacks is treated like a bubble
    assign hart_ok = fetch.valid && (int'(fetch.hart) < NUM_HARTS);

    assign is_call = hart_ok && rd_link &&
                     ((opcode == ras_pkg::OPC_JAL) || (opcode == ras_pkg::OPC_JALR));
    assign is_ret  = hart_ok && (opcode == ras_pkg::OPC_JALR) && (rd == 5'd0) && rs1_link;

    always_comb begin
        for (int i = 0; i < NUM_HARTS; i++) begin
            hart_sel[i] = (int'(fetch.hart) == i);
        end
    end

    // -------------------- strobes

    always_ff @(posedge clk) begin
        if (!resetn) begin
            push      <= '0;
            pop       <= '0;
            pop_valid <= 1'b0;
        end else begin
            push      <= is_call ? hart_sel : '0;
            pop       <= is_ret ? hart_sel : '0;
            pop_valid <= is_ret;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            ret_pc   <= fetch.pc + 32'd4;  // No compressed calls, so always the next word
            pop_hart <= fetch.hart;
        end
    end

endmodule

`default_nettype wire

/* ras_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module ras_ram #(
    parameter int ADDR_BITS = 3,
    parameter int DATA_BITS = 32
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] addr,
    input  logic [DATA_BITS-1:0] wdata,
    output logic [DATA_BITS-1:0] rdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read is combinational so a pop sees the entry in the same cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* ras.sv */
`timescale 1ns/100ps
`default_nettype none

module ras #(
    parameter int RAS_SIZE = 8
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           push,
    input  logic           pop,
    input  ras_pkg::addr_t ret_pc,
    output ras_pkg::addr_t top_pc,
    output logic           fail,
    output logic           err_overflow,
    output logic           err_underflow
);

    localparam int PTR_BITS = $clog2(RAS_SIZE);
    localparam int CNT_BITS = PTR_BITS + 1;

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    ptr_t top;
    ptr_t top_nxt;
    ptr_t ram_addr;
    logic empty;
    logic empty_nxt;
    logic full;
    cnt_t ovf_cnt;           // Pushes dropped while full
    cnt_t ovf_cnt_nxt;
    logic cnt_sat;
    logic err_overflow_nxt;
    logic err_underflow_nxt;
    logic ram_we;

    // top points at the newest entry; slot 0 is valid only when not empty
    assign full    = !empty && (&top);
    assign cnt_sat = &ovf_cnt;

    // -------------------- next state

    always_comb begin
        top_nxt           = top;
        empty_nxt         = empty;
        ovf_cnt_nxt       = ovf_cnt;
        err_overflow_nxt  = err_overflow;
        err_underflow_nxt = err_underflow;
        if (push) begin
            if (empty) begin
                empty_nxt = 1'b0;  // First entry lands in slot 0
            end else if (!full) begin
                top_nxt = top + 1'b1;
            end else if (!cnt_sat) begin
                ovf_cnt_nxt = ovf_cnt + 1'b1;
            end else begin
                err_overflow_nxt = 1'b1;
            end
        end else if (pop) begin
            if (ovf_cnt != '0) begin
                // Matches a dropped push, so the stored entries stay put
                ovf_cnt_nxt = ovf_cnt - 1'b1;
            end else if (empty) begin
                err_underflow_nxt = 1'b1;
            end else if (top == '0) begin
                empty_nxt = 1'b1;
            end else begin
                top_nxt = top - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            top           <= '0;
            empty         <= 1'b1;
            ovf_cnt       <= '0;
            err_overflow  <= 1'b0;
            err_underflow <= 1'b0;
        end else begin
            top           <= top_nxt;
            empty         <= empty_nxt;
            ovf_cnt       <= ovf_cnt_nxt;
            err_overflow  <= err_overflow_nxt;
            err_underflow <= err_underflow_nxt;
        end
    end

    // -------------------- storage

    assign ram_addr = push ? top_nxt : top;
    assign ram_we   = push && !full;

    ras_ram #(
        .ADDR_BITS (PTR_BITS),
        .DATA_BITS ($bits(ras_pkg::addr_t))
    ) i_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ret_pc),
        .rdata (top_pc)
    );

    // The top entry cannot be trusted while dropped pushes are outstanding
    assign fail = empty || (ovf_cnt != '0);

endmodule

`default_nettype wire

/* ras_predict_out.sv */
`timescale 1ns/100ps
`default_nettype none

module ras_predict_out #(
    parameter int NUM_HARTS = 4
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            pop_valid,
    input  ras_pkg::hart_t                  pop_hart,
    input  ras_pkg::addr_t [NUM_HARTS-1:0]  top_pc,
    input  logic [NUM_HARTS-1:0]            fail,
    output ras_pkg::ras_pred_t              pred
);

    ras_pkg::addr_t sel_pc;
    logic           sel_fail;
    logic           pred_valid;
    ras_pkg::hart_t pred_hart;
    ras_pkg::addr_t pred_target;
    logic           pred_fail;

    // Stack 0 answers for a hart number beyond the built stacks
    always_comb begin
        sel_pc   = top_pc[0];
        sel_fail = fail[0];
        for (int i = 1; i < NUM_HARTS; i++) begin
            if (int'(pop_hart) == i) begin
                sel_pc   = top_pc[i];
                sel_fail = fail[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= pop_valid;  // One cycle pulse per return
        end
    end

    always_ff @(posedge clk) begin
        if (pop_valid) begin
            pred_hart   <= pop_hart;
            pred_target <= sel_pc;
            pred_fail   <= sel_fail;
        end
    end

    assign pred = '{
        valid:  pred_valid,
        hart:   pred_hart,
        target: pred_target,
        fail:   pred_fail
    };

endmodule

`default_nettype wire

/* ras_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module ras_unit #(
    parameter int NUM_HARTS = 4,
    parameter int RAS_SIZE  = 8
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  ras_pkg::fetch_req_t  fetch,
    output ras_pkg::ras_pred_t   pred,
    output logic [NUM_HARTS-1:0] err_overflow,
    output logic [NUM_HARTS-1:0] err_underflow
);

    logic [NUM_HARTS-1:0]           push;
    logic [NUM_HARTS-1:0]           pop;
    ras_pkg::addr_t                 ret_pc;
    logic                           pop_valid;
    ras_pkg::hart_t                 pop_hart;
    ras_pkg::addr_t [NUM_HARTS-1:0] top_pc;
    logic [NUM_HARTS-1:0]           fail;

    call_ret_decode #(
        .NUM_HARTS (NUM_HARTS)
    ) i_decode (
        .clk       (clk),
        .resetn    (resetn),
        .fetch     (fetch),
        .push      (push),
        .pop       (pop),
        .ret_pc    (ret_pc),
        .pop_valid (pop_valid),
        .pop_hart  (pop_hart)
    );

    // -------------------- one stack per hart

    for (genvar i = 0; i < NUM_HARTS; i++) begin : g_stack
        ras #(
            .RAS_SIZE (RAS_SIZE)
        ) i_ras (
            .clk           (clk),
            .resetn        (resetn),
            .push          (push[i]),
            .pop           (pop[i]),
            .ret_pc        (ret_pc),
            .top_pc        (top_pc[i]),
            .fail          (fail[i]),
            .err_overflow  (err_overflow[i]),
            .err_underflow (err_underflow[i])
        );
    end

    ras_predict_out #(
        .NUM_HARTS (NUM_HARTS)
    ) i_predict_out (
        .clk       (clk),
        .resetn    (resetn),
        .pop_valid (pop_valid),
        .pop_hart  (pop_hart),
        .top_pc    (top_pc),
        .fail      (fail),
        .pred      (pred)
    );

endmodule

`default_nettype wire

/* ras_unit_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module ras_unit_sva #(
    parameter int NUM_HARTS = 4
) (
    input logic                 clk,
    input logic                 resetn,
    input logic [NUM_HARTS-1:0] push,
    input logic [NUM_HARTS-1:0] pop,
    input logic                 pop_valid,
    input ras_pkg::ras_pred_t   pred,
    input logic [NUM_HARTS-1:0] err_overflow,
    input logic [NUM_HARTS-1:0] err_underflow
);

    // A registered pop turns into a prediction on the next edge
    a_pred_follows_pop: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> (pred.valid == $past(pop_valid)))
        else $error("pred.valid does not follow pop_valid by one cycle");

    a_no_push_and_pop: assert property (@(posedge clk) disable iff (!resetn)
        (push & pop) == '0)
        else $error("push and pop high together for one hart");

    // -------------------- sticky errors

    a_overflow_sticky: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> ((err_overflow & $past(err_overflow)) == $past(err_overflow)))
        else $error("err_overflow bit fell without reset");

    a_underflow_sticky: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> ((err_underflow & $past(err_underflow)) == $past(err_underflow)))
        else $error("err_underflow bit fell without reset");

endmodule

bind ras_unit ras_unit_sva #(
    .NUM_HARTS (NUM_HARTS)
) i_sva (
    .clk           (clk),
    .resetn        (resetn),
    .push          (push),
    .pop           (pop),
    .pop_valid     (pop_valid),
    .pred          (pred),
    .err_overflow  (err_overflow),
    .err_underflow (err_underflow)
);

`default_nettype wire

/* tb_ras_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ras_unit;

    localparam int NUM_HARTS     = 4;
    localparam int RAS_SIZE      = 4;
    localparam int OVF_MAX       = 2 * RAS_SIZE - 1;  // Largest count of dropped pushes
    localparam int RESET_TIMEOUT = 20;

    typedef enum logic [1:0] {K_CALL, K_RET, K_OTHER, K_IDLE} kind_t;

    typedef struct {
        string          name;
        ras_pkg::hart_t hart;
        kind_t          kind;
        ras_pkg::addr_t pc;
    } step_t;

    typedef struct packed {
        logic                 valid;
        ras_pkg::hart_t       hart;
        ras_pkg::addr_t       target;
        logic                 fail;
        logic                 check_target;
        logic [NUM_HARTS-1:0] ovf;
        logic [NUM_HARTS-1:0] unf;
    } expect_t;

    logic                 clk = 1'b0;
    logic                 resetn;
    ras_pkg::fetch_req_t  fetch;
    ras_pkg::ras_pred_t   pred;
    logic [NUM_HARTS-1:0] err_overflow;
    logic [NUM_HARTS-1:0] err_underflow;

    logic [31:0]          lcg_state = 32'h2e32e702;
    step_t                steps[$];
    expect_t              exp_q[$];
    string                name_q[$];

    // Reference model of every hart's stack
    ras_pkg::addr_t       model_mem [NUM_HARTS][RAS_SIZE];
    int                   model_depth [NUM_HARTS];
    int                   model_ovf [NUM_HARTS];
    logic [NUM_HARTS-1:0] model_ovf_err;
    logic [NUM_HARTS-1:0] model_unf_err;

    always #2 clk = ~clk;

    ras_unit #(
        .NUM_HARTS (NUM_HARTS),
        .RAS_SIZE  (RAS_SIZE)
    ) i_dut (
        .clk           (clk),
        .resetn        (resetn),
        .fetch         (fetch),
        .pred          (pred),
        .err_overflow  (err_overflow),
        .err_underflow (err_underflow)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // -------------------- stimulus

    function automatic ras_pkg::instr_t make_instr(kind_t kind);
        logic [31:0] r;
        logic [4:0]  link;
        r    = next_random();
        link = r[0] ? 5'd5 : 5'd1;
        case (kind)
            K_CALL: begin
                if (r[1]) return {r[31:12], link, ras_pkg::OPC_JAL};
                return {r[31:20], r[19:15], 3'b000, link, ras_pkg::OPC_JALR};
            end
            K_OTHER: begin
                case (r[3:2])
                    2'd0:    return {r[31:12], 5'd0, ras_pkg::OPC_JAL};             // Plain jump
                    2'd1:    return {r[31:20], 5'd1, 3'b000, 5'd2, ras_pkg::OPC_JALR};
                    default: return {r[31:7], 7'b0010011};
                endcase
            end
            default: return {r[31:20], link, 3'b000, 5'd0, ras_pkg::OPC_JALR};  // Return shape
        endcase
    endfunction

    task automatic add_step(input string name, input int hart, input kind_t kind);
        step_t s;
        s.name = name;
        s.hart = ras_pkg::hart_t'(hart);
        s.kind = kind;
        s.pc   = next_random() & 32'hffff_fffc;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] r;
        for (int i = 0; i < 3; i++) add_step("nest_call", 0, K_CALL);
        for (int i = 0; i < 3; i++) add_step("nest_ret", 0, K_RET);
        add_step("b2b_call", 1, K_CALL);
        add_step("b2b_ret", 1, K_RET);
        add_step("mix_call", 0, K_CALL);
        add_step("mix_call", 1, K_CALL);
        add_step("mix_call", 2, K_CALL);
        add_step("mix_call", 3, K_CALL);
        add_step("mix_call", 2, K_CALL);
        add_step("mix_ret", 3, K_RET);
        add_step("mix_ret", 2, K_RET);
        add_step("mix_call", 0, K_CALL);
        add_step("mix_ret", 1, K_RET);
        add_step("mix_ret", 2, K_RET);
        add_step("mix_ret", 0, K_RET);
        add_step("mix_ret", 0, K_RET);
        for (int i = 0; i < 4; i++) add_step("filler", i, K_OTHER);
        for (int i = 0; i < 4; i++) add_step("invalid", i, K_IDLE);
        for (int i = 0; i < 6; i++) add_step("ovf_call", 2, K_CALL);
        for (int i = 0; i < 6; i++) add_step("ovf_ret", 2, K_RET);
        add_step("empty_ret", 1, K_RET);
        // Fills one stack and runs its dropped-push counter into saturation
        for (int i = 0; i < RAS_SIZE + OVF_MAX + 1; i++) add_step("sat_call", 3, K_CALL);
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            add_step("random", int'(r[1:0]), kind_t'(r[3:2]));
        end
        add_step("drain", 0, K_IDLE);
        add_step("drain", 0, K_IDLE);
    endtask

    // -------------------- model and checks

    task automatic model_step(input step_t s, output expect_t e);
        int h;
        h = int'(s.hart);
        e = '0;
        if (s.kind == K_CALL) begin
            if (model_depth[h] < RAS_SIZE) begin
                model_mem[h][model_depth[h]] = s.pc + 32'd4;
                model_depth[h]++;
            end else if (model_ovf[h] < OVF_MAX) begin
                model_ovf[h]++;
            end else begin
                model_ovf_err[h] = 1'b1;
            end
        end else if (s.kind == K_RET) begin
            e.valid        = 1'b1;
            e.hart         = s.hart;
            e.fail         = (model_depth[h] == 0) || (model_ovf[h] != 0);
            e.check_target = (model_depth[h] != 0);
            if (model_depth[h] != 0) e.target = model_mem[h][model_depth[h] - 1];
            if (model_ovf[h] != 0) begin
                model_ovf[h]--;
            end else if (model_depth[h] == 0) begin
                model_unf_err[h] = 1'b1;
            end else begin
                model_depth[h]--;
            end
        end
        e.ovf = model_ovf_err;
        e.unf = model_unf_err;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_front();
        expect_t e;
        string   n;
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_value({n, " pred.valid"}, 32'(e.valid), 32'(pred.valid));
        if (e.valid) begin
            check_value({n, " pred.hart"}, 32'(e.hart), 32'(pred.hart));
            check_value({n, " pred.fail"}, 32'(e.fail), 32'(pred.fail));
            if (e.check_target) check_value({n, " pred.target"}, e.target, pred.target);
        end
        check_value({n, " err_overflow"}, 32'(e.ovf), 32'(err_overflow));
        check_value({n, " err_underflow"}, 32'(e.unf), 32'(err_underflow));
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (resetn !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (resetn !== 1'b1) begin
            $display("Timed out waiting for reset release");
            $display("Simulation failed");
            $fatal(1, "reset timeout");
        end
    endtask

    // -------------------- main sequence

    initial begin
        ras_pkg::fetch_req_t req;
        expect_t             e;
        resetn        = 1'b0;
        fetch         = '0;
        model_ovf_err = '0;
        model_unf_err = '0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            model_depth[h] = 0;
            model_ovf[h]   = 0;
        end
        build_table();
        // Two steps are in flight before the first result shows up
        for (int i = 0; i < 2; i++) begin
            exp_q.push_back('0);
            name_q.push_back("after_reset");
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        wait_reset_release();
        foreach (steps[i]) begin
            @(posedge clk);
            req.valid = (steps[i].kind != K_IDLE);
            req.hart  = steps[i].hart;
            req.pc    = steps[i].pc;
            req.instr = make_instr(steps[i].kind);
            fetch <= req;
            model_step(steps[i], e);
            exp_q.push_back(e);
            name_q.push_back(steps[i].name);
            @(negedge clk);
            compare_front();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
ras_pkg.sv
call_ret_decode.sv
ras_ram.sv
ras.sv
ras_predict_out.sv
ras_unit.sv
ras_unit_sva.sv
tb_ras_unit.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ras_unit
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)
